/* compile.f */
+incdir+design
design/sys_instr_pkg.sv
design/sys_csr_pkg.sv
design/sys_cmd_decode.sv
design/sys_mtimer.sv
design/sys_csr_file.sv
design/sys_pipe_ctrl.sv
design/sys_pipe.sv
verification/sys_pipe_sva.sv
verification/sys_pipe_tb.sv

/* design/sys_cmd_decode.sv */
`timescale 1ns/1ps

module sys_cmd_decode
  import sys_instr_pkg::*;
(
  input  sys_instr_u  instr_i,
  output sys_op_e     op_o,
  output logic [11:0] csr_addr_o,
  output logic        use_uimm_o,
  output logic        src_zero_o
);

  logic is_system;

  assign is_system  = (instr_i.csr.opcode == sys_opcode_system);
  assign csr_addr_o = instr_i.csr.csr;
  assign use_uimm_o = instr_i.csr.funct3[2];  // csrrwi, csrrsi, csrrci
  assign src_zero_o = (instr_i.csr.rs1 == 5'd0);  // x0 or uimm 0

  always_comb
  begin
    op_o = e_sys_illegal;
    if (is_system && instr_i.csr.funct3 != 3'b000)
    begin
      case (instr_i.csr.funct3[1:0])
        2'b01:   op_o = e_csrrw;
        2'b10:   op_o = e_csrrs;
        2'b11:   op_o = e_csrrc;
        default: op_o = e_sys_illegal;  // funct3 100 is reserved
      endcase
    end
    else if (is_system && instr_i.priv.funct3 == 3'b000)
    begin
      if (instr_i.priv.funct7 == 7'd0 && instr_i.priv.rs2 == 5'd0)
      begin
        op_o = e_ecall;
      end
      else if (instr_i.priv.funct7 == 7'd0 && instr_i.priv.rs2 == 5'd1)
      begin
        op_o = e_ebreak;
      end
      else if (instr_i.priv.funct7 == sys_funct7_mret && instr_i.priv.rs2 == 5'd2)
      begin
        op_o = e_mret;
      end
    end
  end

endmodule

/* design/sys_csr_file.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_csr_file
  import sys_instr_pkg::*;
  import sys_csr_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    commit_v_i,
  input  sys_op_e                 op_i,
  input  logic [11:0]             csr_addr_i,
  input  logic [`SYS_XLEN-1:0]    wdata_i,
  input  logic                    src_zero_i,
  input  logic [`SYS_XLEN-1:0]    pc_i,
  input  logic                    software_irq_i,
  input  logic                    external_irq_i,
  input  logic                    timer_irq_i,
  input  logic [`SYS_TIMER_W-1:0] mtime_i,
  input  logic [`SYS_TIMER_W-1:0] mtimecmp_i,
  input  logic                    int_take_i,
  output logic [`SYS_XLEN-1:0]    result_o,
  output logic                    rd_w_v_o,
  output logic                    exc_v_o,
  output logic                    redirect_v_o,
  output logic [`SYS_XLEN-1:0]    redirect_pc_o,
  output logic                    int_ready_o,
  output logic                    cmp_we_o,
  output logic [`SYS_TIMER_W-1:0] cmp_data_o
);

  logic                 mstatus_mie_q, mstatus_mpie_q;
  logic                 msie_q, mtie_q, meie_q;
  logic [`SYS_XLEN-1:0] mtvec_q, mepc_q, mcause_q, mscratch_q, npc_q;
  logic [`SYS_XLEN-1:0] mstatus_rd, mie_rd, mip_rd, rdata, new_val;
  logic [`SYS_XLEN-1:0] trap_code, irq_code, mtvec_base;
  logic                 addr_valid, is_csr, wr_req, exc, do_write, do_mret;
  logic                 pend_ext, pend_sw, pend_tmr;

  always_comb
  begin
    mstatus_rd                   = '0;
    mstatus_rd[mstatus_mie_bit]  = mstatus_mie_q;
    mstatus_rd[mstatus_mpie_bit] = mstatus_mpie_q;
    mie_rd                       = '0;
    mie_rd[mie_msie_bit]         = msie_q;
    mie_rd[mie_mtie_bit]         = mtie_q;
    mie_rd[mie_meie_bit]         = meie_q;
    mip_rd                       = '0;  // raw lines, not masked by mie
    mip_rd[mie_msie_bit]         = software_irq_i;
    mip_rd[mie_mtie_bit]         = timer_irq_i;
    mip_rd[mie_meie_bit]         = external_irq_i;
  end

  always_comb
  begin
    rdata      = '0;
    addr_valid = 1'b1;
    case (csr_addr_i)
      csr_mstatus:  rdata = mstatus_rd;
      csr_mie:      rdata = mie_rd;
      csr_mtvec:    rdata = mtvec_q;
      csr_mscratch: rdata = mscratch_q;
      csr_mepc:     rdata = mepc_q;
      csr_mcause:   rdata = mcause_q;
      csr_mip:      rdata = mip_rd;
      csr_mtimecmp: rdata = `SYS_XLEN'(mtimecmp_i);
      csr_time:     rdata = `SYS_XLEN'(mtime_i);
      default:      addr_valid = 1'b0;
    endcase
  end

  always_comb
  begin
    case (op_i)
      e_csrrw: new_val = wdata_i;
      e_csrrs: new_val = rdata | wdata_i;
      e_csrrc: new_val = rdata & ~wdata_i;
      default: new_val = rdata;
    endcase
  end

  assign is_csr   = (op_i == e_csrrw) || (op_i == e_csrrs) || (op_i == e_csrrc);
  assign wr_req   = is_csr && ((op_i == e_csrrw) || !src_zero_i);
  assign exc      = (is_csr && (!addr_valid || (wr_req && csr_addr_i[11:10] == 2'b11)))
                    || (op_i == e_sys_illegal) || (op_i == e_ecall) || (op_i == e_ebreak);
  assign do_write = commit_v_i && wr_req && !exc;
  assign do_mret  = commit_v_i && (op_i == e_mret);

  assign trap_code = (op_i == e_ecall)  ? mcause_ecall_m :
                     (op_i == e_ebreak) ? mcause_breakpoint : mcause_illegal_instr;

  assign pend_ext    = external_irq_i && meie_q;
  assign pend_sw     = software_irq_i && msie_q;
  assign pend_tmr    = timer_irq_i && mtie_q;
  assign int_ready_o = mstatus_mie_q && (pend_ext || pend_sw || pend_tmr);
  assign irq_code    = pend_ext ? mcause_m_ext_int :
                       pend_sw  ? mcause_m_soft_int : mcause_m_timer_int;

  assign mtvec_base    = {mtvec_q[`SYS_XLEN-1:2], 2'b00};
  assign result_o      = rdata;
  assign rd_w_v_o      = commit_v_i && is_csr && !exc;
  assign exc_v_o       = commit_v_i && exc;
  assign redirect_v_o  = exc_v_o || do_mret;
  assign redirect_pc_o = do_mret ? mepc_q : mtvec_base;  // trap and interrupt share mtvec
  assign cmp_we_o      = do_write && (csr_addr_i == csr_mtimecmp);
  assign cmp_data_o    = new_val[`SYS_TIMER_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      msie_q         <= 1'b0;
      mtie_q         <= 1'b0;
      meie_q         <= 1'b0;
      mtvec_q        <= `SYS_RESET_MTVEC;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mscratch_q     <= '0;
      npc_q          <= `SYS_RESET_PC;
    end
    else if (int_take_i)
    begin
      mepc_q         <= npc_q;
      mcause_q       <= irq_code;
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end
    else if (exc_v_o)
    begin
      mepc_q         <= pc_i;
      mcause_q       <= trap_code;
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end
    else if (do_mret)
    begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end
    else
    begin
      if (do_write)
      begin
        case (csr_addr_i)
          csr_mstatus:
          begin
            mstatus_mie_q  <= new_val[mstatus_mie_bit];
            mstatus_mpie_q <= new_val[mstatus_mpie_bit];
          end
          csr_mie:
          begin
            msie_q <= new_val[mie_msie_bit];
            mtie_q <= new_val[mie_mtie_bit];
            meie_q <= new_val[mie_meie_bit];
          end
          csr_mtvec:    mtvec_q    <= new_val;
          csr_mscratch: mscratch_q <= new_val;
          csr_mepc:     mepc_q     <= new_val;
          csr_mcause:   mcause_q   <= new_val;
          default: ;  // mip ignores writes, mtimecmp lives in the timer
        endcase
      end
      if (commit_v_i)
      begin
        npc_q <= pc_i + `SYS_XLEN'd4;
      end
    end
  end

endmodule

/* design/sys_csr_pkg.sv */
package sys_csr_pkg;

  typedef enum logic [11:0] {
    csr_mstatus  = 12'h300,
    csr_mie      = 12'h304,
    csr_mtvec    = 12'h305,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mip      = 12'h344,
    csr_mtimecmp = 12'h7C0,  // custom, machine read/write space
    csr_time     = 12'hC01
  } csr_addr_e;

  // synchronous exceptions
  localparam logic [31:0] mcause_illegal_instr = 32'd2;
  localparam logic [31:0] mcause_breakpoint    = 32'd3;
  localparam logic [31:0] mcause_ecall_m       = 32'd11;

  // interrupts carry bit 31
  localparam logic [31:0] mcause_m_soft_int  = 32'h8000_0003;
  localparam logic [31:0] mcause_m_timer_int = 32'h8000_0007;
  localparam logic [31:0] mcause_m_ext_int   = 32'h8000_000B;

  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mie_msie_bit     = 3;  // same positions in mip
  localparam int mie_mtie_bit     = 7;
  localparam int mie_meie_bit     = 11;

endpackage

/* design/sys_instr_pkg.sv */
package sys_instr_pkg;

  localparam logic [6:0] sys_opcode_system = 7'b1110011;
  localparam logic [6:0] sys_funct7_mret   = 7'b0011000;

  // csr instructions, I-type with the immediate as csr address
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;  // rs1 index or uimm
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_csr_view_s;

  // ecall, ebreak, mret
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } sys_priv_view_s;

  typedef union packed {
    sys_csr_view_s  csr;
    sys_priv_view_s priv;
  } sys_instr_u;

  typedef enum logic [3:0] {
    e_sys_none    = 4'd0,
    e_csrrw       = 4'd1,
    e_csrrs       = 4'd2,
    e_csrrc       = 4'd3,
    e_ecall       = 4'd4,
    e_ebreak      = 4'd5,
    e_mret        = 4'd6,
    e_sys_illegal = 4'd7
  } sys_op_e;

endpackage

/* design/sys_mtimer.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_mtimer
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cmp_we_i,
  input  logic [`SYS_TIMER_W-1:0] cmp_data_i,
  output logic [`SYS_TIMER_W-1:0] mtime_o,
  output logic [`SYS_TIMER_W-1:0] mtimecmp_o,
  output logic                   timer_irq_o
);

  logic [`SYS_TIMER_W-1:0] mtime_q;
  logic [`SYS_TIMER_W-1:0] mtimecmp_q;
  logic                    irq_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // no interrupt until software sets a compare value
      irq_q      <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 1'b1;
      if (cmp_we_i)
      begin
        mtimecmp_q <= cmp_data_i;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign mtime_o     = mtime_q;
  assign mtimecmp_o  = mtimecmp_q;
  assign timer_irq_o = irq_q;

endmodule

/* design/sys_params.svh */
`ifndef SYS_PARAMS_SVH
`define SYS_PARAMS_SVH

// data and address width
`define SYS_XLEN 32

// mtime and mtimecmp width
`define SYS_TIMER_W 32

// next-pc register after reset, used as mepc for an early interrupt
`define SYS_RESET_PC 32'h0000_0000

// trap vector after reset, direct mode only
`define SYS_RESET_MTVEC 32'h0000_0100

`endif

/* design/sys_pipe.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_pipe
  import sys_instr_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  output logic                 ack_o,
  input  sys_instr_u           instr_i,
  input  logic [`SYS_XLEN-1:0] pc_i,
  input  logic [`SYS_XLEN-1:0] rs1_val_i,
  output logic [`SYS_XLEN-1:0] result_o,
  output logic                 rd_w_v_o,
  output logic                 exc_v_o,
  output logic                 redirect_v_o,
  output logic [`SYS_XLEN-1:0] redirect_pc_o,
  output logic                 int_v_o,
  input  logic                 software_irq_i,
  input  logic                 external_irq_i
);

  sys_op_e                 dec_op, cmd_op;
  logic [11:0]             dec_csr_addr, cmd_csr_addr;
  logic                    dec_use_uimm, dec_src_zero, cmd_src_zero, cmd_v;
  logic [`SYS_XLEN-1:0]    cmd_wdata, cmd_pc, csr_result, csr_redirect_pc;
  logic                    csr_rd_w_v, csr_exc_v, csr_redirect_v, int_ready, int_take;
  logic                    cmp_we, timer_irq;
  logic [`SYS_TIMER_W-1:0] cmp_data, mtime, mtimecmp;

  sys_cmd_decode u_decode (
    .instr_i(instr_i), .op_o(dec_op), .csr_addr_o(dec_csr_addr),
    .use_uimm_o(dec_use_uimm), .src_zero_o(dec_src_zero)
  );

  sys_pipe_ctrl u_ctrl (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_o(ack_o), .int_v_o(int_v_o),
    .op_i(dec_op), .csr_addr_i(dec_csr_addr), .use_uimm_i(dec_use_uimm),
    .src_zero_i(dec_src_zero), .uimm_i(instr_i.csr.rs1), .pc_i(pc_i),
    .rs1_val_i(rs1_val_i), .int_ready_i(int_ready), .csr_result_i(csr_result),
    .csr_rd_w_v_i(csr_rd_w_v), .csr_exc_v_i(csr_exc_v), .csr_redirect_v_i(csr_redirect_v),
    .csr_redirect_pc_i(csr_redirect_pc), .commit_v_o(cmd_v), .op_o(cmd_op),
    .csr_addr_o(cmd_csr_addr), .wdata_o(cmd_wdata), .src_zero_o(cmd_src_zero),
    .pc_o(cmd_pc), .int_take_o(int_take), .result_o(result_o), .rd_w_v_o(rd_w_v_o),
    .exc_v_o(exc_v_o), .redirect_v_o(redirect_v_o), .redirect_pc_o(redirect_pc_o)
  );

  sys_csr_file u_csr (
    .clk_i(clk_i), .rst_i(rst_i), .commit_v_i(cmd_v), .op_i(cmd_op),
    .csr_addr_i(cmd_csr_addr), .wdata_i(cmd_wdata), .src_zero_i(cmd_src_zero),
    .pc_i(cmd_pc), .software_irq_i(software_irq_i), .external_irq_i(external_irq_i),
    .timer_irq_i(timer_irq), .mtime_i(mtime), .mtimecmp_i(mtimecmp), .int_take_i(int_take),
    .result_o(csr_result), .rd_w_v_o(csr_rd_w_v), .exc_v_o(csr_exc_v),
    .redirect_v_o(csr_redirect_v), .redirect_pc_o(csr_redirect_pc),
    .int_ready_o(int_ready), .cmp_we_o(cmp_we), .cmp_data_o(cmp_data)
  );

  sys_mtimer u_mtimer (
    .clk_i(clk_i), .rst_i(rst_i), .cmp_we_i(cmp_we), .cmp_data_i(cmp_data),
    .mtime_o(mtime), .mtimecmp_o(mtimecmp), .timer_irq_o(timer_irq)
  );

endmodule

/* design/sys_pipe_ctrl.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_pipe_ctrl
  import sys_instr_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  output logic                 ack_o,
  output logic                 int_v_o,
  input  sys_op_e              op_i,
  input  logic [11:0]          csr_addr_i,
  input  logic                 use_uimm_i,
  input  logic                 src_zero_i,
  input  logic [4:0]           uimm_i,
  input  logic [`SYS_XLEN-1:0] pc_i,
  input  logic [`SYS_XLEN-1:0] rs1_val_i,
  input  logic                 int_ready_i,
  input  logic [`SYS_XLEN-1:0] csr_result_i,
  input  logic                 csr_rd_w_v_i,
  input  logic                 csr_exc_v_i,
  input  logic                 csr_redirect_v_i,
  input  logic [`SYS_XLEN-1:0] csr_redirect_pc_i,
  output logic                 commit_v_o,
  output sys_op_e              op_o,
  output logic [11:0]          csr_addr_o,
  output logic [`SYS_XLEN-1:0] wdata_o,
  output logic                 src_zero_o,
  output logic [`SYS_XLEN-1:0] pc_o,
  output logic                 int_take_o,
  output logic [`SYS_XLEN-1:0] result_o,
  output logic                 rd_w_v_o,
  output logic                 exc_v_o,
  output logic                 redirect_v_o,
  output logic [`SYS_XLEN-1:0] redirect_pc_o
);

  typedef enum logic [2:0] {st_idle, st_decode, st_commit, st_ack, st_int} state_e;

  state_e               state_q, state_d;
  logic                 accept, leave;
  logic [`SYS_XLEN-1:0] hold_result, hold_redirect_pc;
  logic                 hold_rd_w_v, hold_exc_v, hold_redirect_v;

  assign accept     = (state_q == st_idle) && req_i;
  assign int_take_o = (state_q == st_idle) && !req_i && int_ready_i;
  assign leave      = ((state_q == st_ack) && !req_i) || (state_q == st_int);
  assign commit_v_o = (state_q == st_decode);
  assign ack_o      = (state_q == st_ack);
  assign int_v_o    = (state_q == st_int);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
      begin
        if (req_i)
          state_d = st_decode;
        else if (int_ready_i)
          state_d = st_int;
      end
      st_decode: state_d = st_commit;
      st_commit: state_d = st_ack;
      st_ack:    state_d = req_i ? st_ack : st_idle;  // late drop just waits here
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      op_o <= e_sys_none;
    else if (accept)
      op_o <= op_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      csr_addr_o <= csr_addr_i;
      wdata_o    <= use_uimm_i ? {{(`SYS_XLEN-5){1'b0}}, uimm_i} : rs1_val_i;
      src_zero_o <= src_zero_i;
      pc_o       <= pc_i;
    end
    if (commit_v_o)  // csr state changes on this edge, keep what it returned
    begin
      hold_result      <= csr_result_i;
      hold_rd_w_v      <= csr_rd_w_v_i;
      hold_exc_v       <= csr_exc_v_i;
      hold_redirect_v  <= csr_redirect_v_i;
      hold_redirect_pc <= csr_redirect_pc_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q       <= st_idle;
      result_o      <= '0;
      rd_w_v_o      <= 1'b0;
      exc_v_o       <= 1'b0;
      redirect_v_o  <= 1'b0;
      redirect_pc_o <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == st_commit)
      begin
        result_o      <= hold_result;
        rd_w_v_o      <= hold_rd_w_v;
        exc_v_o       <= hold_exc_v;
        redirect_v_o  <= hold_redirect_v;
        redirect_pc_o <= hold_redirect_pc;
      end
      else if (int_take_o)
      begin
        redirect_pc_o <= csr_redirect_pc_i;  // mtvec, shown with int_v_o
      end
      else if (leave)
      begin
        result_o      <= '0;
        rd_w_v_o      <= 1'b0;
        exc_v_o       <= 1'b0;
        redirect_v_o  <= 1'b0;
        redirect_pc_o <= '0;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the sys_pipe testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module sys_pipe_tb \
  -o sys_pipe_sim \
  && ./obj_dir/sys_pipe_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && echo "result: failed" && exit 1
grep -q ">>> PASS" sim.log && echo "result: passed" && exit 0
echo "result: no verdict found in sim.log" && exit 1

/* verification/sys_pipe_sva.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_pipe_sva
(
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 req_i,
  input logic                 ack_o,
  input logic                 int_v_o,
  input logic                 rd_w_v_o,
  input logic                 exc_v_o,
  input logic                 redirect_v_o,
  input logic [`SYS_XLEN-1:0] result_o,
  input logic [`SYS_XLEN-1:0] redirect_pc_o
);

  int fail_cnt = 0;

  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_o) |-> req_i)
    else
    begin
      $error("ack_o rose while req_i was low");
      fail_cnt++;
    end

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(ack_o) |-> !$past(req_i))
    else
    begin
      $error("ack_o fell before req_i was dropped");
      fail_cnt++;
    end

  // outputs hold for the whole ack phase, late drops included
  ack_outputs_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o && $past(ack_o) |-> $stable(result_o) && $stable(redirect_pc_o)
      && $stable(redirect_v_o) && $stable(rd_w_v_o) && $stable(exc_v_o))
    else
    begin
      $error("pipe outputs changed while ack_o was high");
      fail_cnt++;
    end

  int_not_with_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    !(int_v_o && ack_o))
    else
    begin
      $error("int_v_o and ack_o were high together");
      fail_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !ack_o && !int_v_o && !redirect_v_o && !exc_v_o)
    else
    begin
      $error("pipe outputs not low after reset");
      fail_cnt++;
    end

endmodule

/* verification/sys_pipe_tb.sv */
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_pipe_tb
  import sys_csr_pkg::*;
();

  localparam int clk_period      = 20;
  localparam int n_handshakes    = 60;
  localparam int hs_cycles       = 10;
  localparam int int_wait_cycles = 40;
  localparam int watchdog_ns     = (n_handshakes * hs_cycles + int_wait_cycles + 8) * clk_period;

  localparam logic [31:0] ecall_w  = 32'h0000_0073;
  localparam logic [31:0] ebreak_w = 32'h0010_0073;
  localparam logic [31:0] mret_w   = 32'h3020_0073;
  localparam logic [2:0]  f_rw     = 3'b001;
  localparam logic [2:0]  f_rs     = 3'b010;
  localparam logic [2:0]  f_rc     = 3'b011;
  localparam logic [2:0]  f_rsi    = 3'b110;
  localparam logic [2:0]  f_rci    = 3'b111;

  logic        clk_i, rst_i, req_i, software_irq_i, external_irq_i;
  logic [31:0] instr_i, pc_i, rs1_val_i, result_o, redirect_pc_o;
  logic        ack_o, rd_w_v_o, exc_v_o, redirect_v_o, int_v_o;

  // shadow CSR state
  logic [31:0] m_mscratch, m_mtvec, m_mepc, m_mcause, m_mie, m_cmp, m_npc, pc_cnt;
  logic        m_st_mie, m_st_mpie;
  logic [31:0] exp_result, exp_rpc;
  logic        exp_rdw, exp_exc, exp_redir;
  integer      seed;
  int          errors;

  sys_pipe dut0 (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_o(ack_o), .instr_i(instr_i),
    .pc_i(pc_i), .rs1_val_i(rs1_val_i), .result_o(result_o), .rd_w_v_o(rd_w_v_o),
    .exc_v_o(exc_v_o), .redirect_v_o(redirect_v_o), .redirect_pc_o(redirect_pc_o),
    .int_v_o(int_v_o), .software_irq_i(software_irq_i), .external_irq_i(external_irq_i)
  );

  bind sys_pipe sys_pipe_sva sva0 (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_o(ack_o), .int_v_o(int_v_o),
    .rd_w_v_o(rd_w_v_o), .exc_v_o(exc_v_o), .redirect_v_o(redirect_v_o),
    .result_o(result_o), .redirect_pc_o(redirect_pc_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    errors++;
  endtask

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_mstatus:  return {24'd0, m_st_mpie, 3'd0, m_st_mie, 3'd0};
      csr_mie:      return m_mie;
      csr_mtvec:    return m_mtvec;
      csr_mscratch: return m_mscratch;
      csr_mepc:     return m_mepc;
      csr_mcause:   return m_mcause;
      csr_mtimecmp: return m_cmp;
      default:      return 32'd0;  // mip and time are never compared
    endcase
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      csr_mstatus:
      begin
        m_st_mie  = val[3];
        m_st_mpie = val[7];
      end
      csr_mie:      m_mie      = val & 32'h0000_0888;
      csr_mtvec:    m_mtvec    = val;
      csr_mscratch: m_mscratch = val;
      csr_mepc:     m_mepc     = val;
      csr_mcause:   m_mcause   = val;
      csr_mtimecmp: m_cmp      = val;
      default: ;
    endcase
  endtask

  task automatic model_trap(input logic [31:0] epc, input logic [31:0] cause);
    m_mepc    = epc;
    m_mcause  = cause;
    m_st_mpie = m_st_mie;
    m_st_mie  = 1'b0;
  endtask

  task automatic check_ack();
    assert (rd_w_v_o == exp_rdw) else report_err("rd_w_v_o", rd_w_v_o, exp_rdw);
    assert (exc_v_o == exp_exc) else report_err("exc_v_o", exc_v_o, exp_exc);
    assert (redirect_v_o == exp_redir) else report_err("redirect_v_o", redirect_v_o, exp_redir);
    assert (!exp_rdw || result_o == exp_result) else report_err("result_o", result_o, exp_result);
    assert (!exp_redir || redirect_pc_o == exp_rpc)
      else report_err("redirect_pc_o", redirect_pc_o, exp_rpc);
  endtask

  // four-phase req/ack with a random hold after ack
  task automatic issue_instr(input logic [31:0] instr, input logic [31:0] rs1v);
    int extra;
    @(posedge clk_i);
    instr_i   <= instr;
    pc_i      <= pc_cnt;
    rs1_val_i <= rs1v;
    req_i     <= 1'b1;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    check_ack();
    extra = $random(seed) & 3;
    repeat (extra) @(negedge clk_i);
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
    pc_cnt = pc_cnt + 32'd4;
  endtask

  task automatic csr_access(input logic [2:0] funct3, input logic [11:0] addr,
                            input logic [4:0] field, input logic [31:0] rs1v);
    logic [31:0] src, old, nv;
    logic        known, writes;
    known      = addr inside {csr_mstatus, csr_mie, csr_mtvec, csr_mscratch, csr_mepc,
                              csr_mcause, csr_mip, csr_mtimecmp, csr_time};
    src        = funct3[2] ? {27'd0, field} : rs1v;
    writes     = (funct3[1:0] == 2'b01) || (field != 5'd0);
    old        = model_read(addr);
    exp_exc    = !known || (writes && addr[11:10] == 2'b11);
    exp_rdw    = !exp_exc;
    exp_redir  = exp_exc;
    exp_result = old;
    exp_rpc    = {m_mtvec[31:2], 2'b00};
    if (exp_exc)
      model_trap(pc_cnt, 32'd2);
    else
    begin
      case (funct3[1:0])
        2'b01:   nv = src;
        2'b10:   nv = old | src;
        default: nv = old & ~src;
      endcase
      if (writes)
        model_write(addr, nv);
      m_npc = pc_cnt + 32'd4;
    end
    issue_instr({addr, field, funct3, 5'd1, 7'b1110011}, rs1v);
  endtask

  task automatic sys_call(input logic [31:0] instr);
    exp_rdw   = 1'b0;
    exp_redir = 1'b1;
    exp_exc   = (instr != mret_w);
    exp_rpc   = exp_exc ? {m_mtvec[31:2], 2'b00} : m_mepc;
    if (instr == ecall_w)
      model_trap(pc_cnt, 32'd11);
    else if (instr == ebreak_w)
      model_trap(pc_cnt, 32'd3);
    else
    begin
      m_st_mie  = m_st_mpie;
      m_st_mpie = 1'b1;
    end
    issue_instr(instr, 32'd0);
  endtask

  task automatic set_irq_lines(input logic sw, input logic ext);
    @(posedge clk_i);
    software_irq_i <= sw;
    external_irq_i <= ext;
  endtask

  task automatic wait_int(input logic [31:0] cause);
    @(negedge clk_i);
    while (!int_v_o) @(negedge clk_i);
    assert (redirect_pc_o == {m_mtvec[31:2], 2'b00})
      else report_err("redirect_pc_o", redirect_pc_o, {m_mtvec[31:2], 2'b00});
    model_trap(m_npc, cause);
  endtask

  task automatic expect_no_int(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk_i);
      assert (!int_v_o)
      else
      begin
        $display("interrupt taken while mstatus MIE was clear at %0t", $time);
        errors++;
      end
    end
  endtask

  initial
  begin
    rst_i          = 1'b1;
    req_i          = 1'b0;
    instr_i        = '0;
    pc_i           = '0;
    rs1_val_i      = '0;
    software_irq_i = 1'b0;
    external_irq_i = 1'b0;
    seed           = 32'hab96_1cba;
    errors         = 0;
    pc_cnt         = 32'h0000_1000;
    m_mscratch     = '0;
    m_mepc         = '0;
    m_mcause       = '0;
    m_mie          = '0;
    m_mtvec        = `SYS_RESET_MTVEC;
    m_npc          = `SYS_RESET_PC;
    m_cmp          = '1;
    m_st_mie       = 1'b0;
    m_st_mpie      = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;

    csr_access(f_rw, csr_mscratch, 5'd5, 32'h1234_5678);
    csr_access(f_rs, csr_mscratch, 5'd0, 32'd0);
    csr_access(f_rs, csr_mscratch, 5'd6, 32'h0000_00F0);
    csr_access(f_rc, csr_mscratch, 5'd7, 32'h1000_0000);
    csr_access(f_rsi, csr_mscratch, 5'h1F, 32'd0);
    csr_access(f_rci, csr_mscratch, 5'h03, 32'd0);
    csr_access(f_rci, csr_mscratch, 5'd0, 32'd0);
    csr_access(f_rc, csr_mscratch, 5'd0, 32'hFFFF_FFFF);  // x0 source skips the write
    csr_access(f_rs, csr_mscratch, 5'd0, 32'd0);

    csr_access(f_rw, csr_mtvec, 5'd2, 32'h0000_0203);
    csr_access(f_rw, csr_time, 5'd2, 32'd1);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    csr_access(f_rs, csr_mepc, 5'd0, 32'd0);
    csr_access(f_rs, 12'h123, 5'd0, 32'd0);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    csr_access(f_rs, csr_mepc, 5'd0, 32'd0);
    csr_access(f_rs, csr_mtimecmp, 5'd0, 32'd0);

    csr_access(f_rsi, csr_mstatus, 5'd8, 32'd0);
    sys_call(ecall_w);
    csr_access(f_rs, csr_mstatus, 5'd0, 32'd0);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    sys_call(mret_w);
    csr_access(f_rs, csr_mstatus, 5'd0, 32'd0);
    sys_call(ebreak_w);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    sys_call(mret_w);

    csr_access(f_rw, csr_mie, 5'd3, 32'h0000_0888);
    set_irq_lines(1'b0, 1'b1);
    wait_int(32'h8000_000B);
    set_irq_lines(1'b0, 1'b0);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    csr_access(f_rs, csr_mepc, 5'd0, 32'd0);
    sys_call(mret_w);

    csr_access(f_rci, csr_mstatus, 5'd8, 32'd0);
    set_irq_lines(1'b1, 1'b1);
    expect_no_int(int_wait_cycles / 2);
    csr_access(f_rsi, csr_mstatus, 5'd8, 32'd0);
    wait_int(32'h8000_000B);  // external beats software
    set_irq_lines(1'b0, 1'b0);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    csr_access(f_rs, csr_mepc, 5'd0, 32'd0);

    csr_access(f_rw, csr_mie, 5'd3, 32'h0000_0080);
    csr_access(f_rw, csr_mtimecmp, 5'd3, 32'd0);
    csr_access(f_rsi, csr_mstatus, 5'd8, 32'd0);
    wait_int(32'h8000_0007);
    csr_access(f_rs, csr_mcause, 5'd0, 32'd0);
    csr_access(f_rs, csr_mepc, 5'd0, 32'd0);

    $display("errors: %0d testbench checks, %0d bound assertions", errors, dut0.sva0.fail_cnt);
    if (errors == 0 && dut0.sva0.fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired, the pipe stopped answering");
    $display("errors: %0d testbench checks, %0d bound assertions", errors, dut0.sva0.fail_cnt);
    $display(">>> FAIL");
    $finish;
  end

endmodule
